// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address arithmetic width
`define CPU_XLEN 32

// Word address width of both memory ports
`define CPU_MEM_AW 12

// Register index width (32 architectural registers)
`define CPU_REG_AW 5

// Special registers
`define CPU_REG_ERROR 30 // Error code and setx target
`define CPU_REG_LINK 31 // Return address from jal

// Overflow codes written to the error register
`define CPU_ERR_ADD 1
`define CPU_ERR_ADDI 2
`define CPU_ERR_SUB 3

// First fetch address after reset
`define CPU_RESET_PC 0

`endif

// File: source/cpuPkg.sv
package cpuPkg;

	// Major opcode in bits 31 to 27
	typedef enum logic [4:0] {
		opR = 5'd0, // ALU op in bits 6 to 2
		opJ = 5'd1,
		opBne = 5'd2,
		opJal = 5'd3,
		opJr = 5'd4,
		opAddi = 5'd5,
		opBlt = 5'd6,
		opSw = 5'd7,
		opLw = 5'd8,
		opSetx = 5'd21,
		opBex = 5'd22
	} opcodeT;

	// R-type function field
	typedef enum logic [4:0] {
		aluAdd = 5'd0,
		aluSub = 5'd1,
		aluAnd = 5'd2,
		aluOr = 5'd3,
		aluSll = 5'd4,
		aluSra = 5'd5
	} aluOpT;

	// Conditional branch flavor resolved in execute
	typedef enum logic [1:0] {
		brNone,
		brBne, // rd != rs
		brBlt, // rd < rs signed
		brBex // r30 != 0
	} branchKindT;

	// Unconditional control transfer
	typedef enum logic [1:0] {
		jmpNone,
		jmpJ,
		jmpJal, // Also links r31
		jmpJr
	} jumpKindT;

	// Source of an execute operand or store data
	typedef enum logic [1:0] {
		bypNone, // Register file value from decode
		bypFromMemory,
		bypFromWriteback
	} bypassSelT;

endpackage

// File: source/instructionDecoder.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module instructionDecoder import cpuPkg::*; (
	input  logic [`CPU_XLEN-1:0]   instruction,
	output opcodeT                 opcode,
	output logic [`CPU_REG_AW-1:0] rd,
	output logic [`CPU_REG_AW-1:0] rs,
	output logic [`CPU_REG_AW-1:0] rt,
	output logic [4:0]             shamt,
	output aluOpT                  aluOp,
	output logic [`CPU_XLEN-1:0]   immediate,
	output logic [`CPU_XLEN-1:0]   target,
	output logic [`CPU_REG_AW-1:0] readRegA,
	output logic [`CPU_REG_AW-1:0] readRegB,
	output logic                   regWrite,
	output logic                   useImmediate,
	output logic                   memLoad,
	output logic                   memStore,
	output logic                   isSetx,
	output branchKindT             branchKind,
	output jumpKindT               jumpKind
);
	// Raw field split
	assign opcode = opcodeT'(instruction[31:27]);
	assign rd = instruction[26:22];
	assign rs = instruction[21:17];
	assign rt = instruction[16:12];
	assign shamt = instruction[11:7];
	assign immediate = {{(`CPU_XLEN-17){instruction[16]}}, instruction[16:0]}; // Sign extend
	assign target = {{(`CPU_XLEN-27){1'b0}}, instruction[26:0]}; // Zero extend

	// Non R-type uses the adder for addi and address math
	assign aluOp = (opcode == opR) ? aluOpT'(instruction[6:2]) : aluAdd;

	always_comb begin
		// Unused read ports stay on r0 so they never hazard
		readRegA = '0;
		readRegB = '0;
		regWrite = 1'b0;
		useImmediate = 1'b0;
		memLoad = 1'b0;
		memStore = 1'b0;
		isSetx = 1'b0;
		branchKind = brNone;
		jumpKind = jmpNone;
		case (opcode)
			opR: begin
				readRegA = rs;
				readRegB = rt;
				// Unknown function codes write nothing
				regWrite = (aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSra});
			end
			opAddi: begin
				readRegA = rs;
				regWrite = 1'b1;
				useImmediate = 1'b1;
			end
			opLw: begin
				readRegA = rs; // Base
				regWrite = 1'b1;
				useImmediate = 1'b1;
				memLoad = 1'b1;
			end
			opSw: begin
				readRegA = rs; // Base
				readRegB = rd; // Store data
				useImmediate = 1'b1;
				memStore = 1'b1;
			end
			opBne, opBlt: begin
				readRegA = rd; // Compared rd against rs
				readRegB = rs;
				branchKind = (opcode == opBne) ? brBne : brBlt;
			end
			opBex: begin
				readRegA = `CPU_REG_AW'(`CPU_REG_ERROR);
				branchKind = brBex;
			end
			opJ: jumpKind = jmpJ;
			opJal: begin
				jumpKind = jmpJal;
				regWrite = 1'b1; // Link into r31
			end
			opJr: begin
				readRegA = rd;
				jumpKind = jmpJr;
			end
			opSetx: begin
				isSetx = 1'b1;
				regWrite = 1'b1;
			end
			default: ; // Treated as a no-op
		endcase
	end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module registerFile (
	input  logic                   clock,
	input  logic                   rst,
	input  logic [`CPU_REG_AW-1:0] readRegA,
	input  logic [`CPU_REG_AW-1:0] readRegB,
	input  logic [`CPU_REG_AW-1:0] writeReg,
	input  logic [`CPU_XLEN-1:0]   writeData,
	input  logic                   writeEnable,
	output logic [`CPU_XLEN-1:0]   readDataA,
	output logic [`CPU_XLEN-1:0]   readDataB
);
	logic [`CPU_XLEN-1:0] regs [0:(2**`CPU_REG_AW)-1];
	logic                 writeLive; // Write that actually lands

	assign writeLive = writeEnable && (writeReg != '0); // r0 is hardwired

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (writeLive) begin
			regs[writeReg] <= writeData;
		end
	end

	// Writeback and decode share a cycle so forward the new value
	assign readDataA = (writeLive && writeReg == readRegA) ? writeData : regs[readRegA];
	assign readDataB = (writeLive && writeReg == readRegB) ? writeData : regs[readRegB];

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module hazardUnit import cpuPkg::*; (
	input  logic [`CPU_REG_AW-1:0] decodeReadA,
	input  logic [`CPU_REG_AW-1:0] decodeReadB,
	input  logic [`CPU_REG_AW-1:0] executeReadA,
	input  logic [`CPU_REG_AW-1:0] executeReadB,
	input  logic                   executeValid,
	input  logic [`CPU_REG_AW-1:0] executeDest,
	input  logic                   executeLoad,
	input  logic [`CPU_REG_AW-1:0] memoryDest,
	input  logic                   memoryRegWrite,
	input  logic                   memoryValid,
	input  logic [`CPU_REG_AW-1:0] writebackDest,
	input  logic                   writebackRegWrite,
	input  logic                   writebackValid,
	input  logic [`CPU_REG_AW-1:0] memoryStoreReg,
	input  logic                   memoryStore,
	output logic                   stall,
	output bypassSelT              bypassA,
	output bypassSelT              bypassB,
	output logic                   bypassStoreData
);
	logic memoryWrites;
	logic writebackWrites;
	logic loadInExecute;

	// Live producers only and never r0
	assign memoryWrites = memoryValid && memoryRegWrite && (memoryDest != '0);
	assign writebackWrites = writebackValid && writebackRegWrite && (writebackDest != '0);
	assign loadInExecute = executeValid && executeLoad && (executeDest != '0);

	// Load data shows up only in writeback so decode waits one cycle
	assign stall = loadInExecute &&
		(executeDest == decodeReadA || executeDest == decodeReadB);

	// Younger producer wins
	function automatic bypassSelT pickSource(input logic [`CPU_REG_AW-1:0] readReg);
		if (memoryWrites && memoryDest == readReg)
			return bypFromMemory;
		else if (writebackWrites && writebackDest == readReg)
			return bypFromWriteback;
		else
			return bypNone;
	endfunction

	assign bypassA = executeValid ? pickSource(executeReadA) : bypNone;
	assign bypassB = executeValid ? pickSource(executeReadB) : bypNone;

	// Store data refreshed from the instruction retiring ahead of it
	assign bypassStoreData = memoryValid && memoryStore && writebackWrites &&
		(writebackDest == memoryStoreReg);

endmodule

// File: source/executeUnit.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module executeUnit import cpuPkg::*; (
	input  logic [`CPU_XLEN-1:0] operandA,
	input  logic [`CPU_XLEN-1:0] operandB,
	input  logic [`CPU_XLEN-1:0] immediate,
	input  logic [`CPU_XLEN-1:0] target,
	input  logic [`CPU_XLEN-1:0] pc,
	input  aluOpT                aluOp,
	input  logic [4:0]           shamt,
	input  opcodeT               opcode,
	input  logic                 useImmediate,
	input  logic                 isSetx,
	input  branchKindT           branchKind,
	input  jumpKindT             jumpKind,
	output logic [`CPU_XLEN-1:0] result,
	output logic                 writeError,
	output logic                 redirect,
	output logic [`CPU_XLEN-1:0] redirectPc
);
	localparam int Msb = `CPU_XLEN - 1;

	logic [`CPU_XLEN-1:0] aluB;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] difference;
	logic [`CPU_XLEN-1:0] aluResult;
	logic [`CPU_XLEN-1:0] nextPc;
	logic [`CPU_XLEN-1:0] branchTarget;
	logic [`CPU_XLEN-1:0] errorCode;
	logic                 overflow;
	logic                 checksOverflow;
	logic                 branchTaken;

	assign aluB = useImmediate ? immediate : operandB; // addi lw sw take the immediate
	assign sum = operandA + aluB;
	assign difference = operandA - aluB;
	assign nextPc = pc + `CPU_XLEN'(1);
	assign branchTarget = nextPc + immediate; // PC + 1 + imm

	always_comb begin
		overflow = 1'b0;
		aluResult = '0;
		case (aluOp)
			aluAdd: begin
				aluResult = sum;
				overflow = (operandA[Msb] == aluB[Msb]) && (sum[Msb] != operandA[Msb]);
			end
			aluSub: begin
				aluResult = difference;
				overflow = (operandA[Msb] != aluB[Msb]) && (difference[Msb] != operandA[Msb]);
			end
			aluAnd: aluResult = operandA & aluB;
			aluOr: aluResult = operandA | aluB;
			aluSll: aluResult = operandA << shamt;
			aluSra: aluResult = $signed(operandA) >>> shamt; // Arithmetic shift
			default: ;
		endcase
	end

	// Address math for loads and stores never traps
	assign checksOverflow = (opcode == opAddi) ||
		(opcode == opR && (aluOp == aluAdd || aluOp == aluSub));
	assign writeError = overflow && checksOverflow;

	always_comb begin
		if (opcode == opAddi)
			errorCode = `CPU_XLEN'(`CPU_ERR_ADDI);
		else if (aluOp == aluSub)
			errorCode = `CPU_XLEN'(`CPU_ERR_SUB);
		else
			errorCode = `CPU_XLEN'(`CPU_ERR_ADD);
	end

	// Value headed for the register file
	always_comb begin
		if (jumpKind == jmpJal)
			result = nextPc; // Link address
		else if (isSetx)
			result = target;
		else if (writeError)
			result = errorCode; // Steered to r30 upstream
		else
			result = aluResult;
	end

	always_comb begin
		case (branchKind)
			brBne: branchTaken = (operandA != operandB);
			brBlt: branchTaken = ($signed(operandA) < $signed(operandB));
			brBex: branchTaken = (operandA != '0); // operandA holds r30
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		redirect = 1'b1;
		case (jumpKind)
			jmpJ, jmpJal: redirectPc = target;
			jmpJr: redirectPc = operandA;
			default: begin
				redirect = branchTaken;
				redirectPc = (branchKind == brBex) ? target : branchTarget;
			end
		endcase
	end

endmodule

// File: source/cpuPipeline.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpuPipeline import cpuPkg::*; (
	input  logic                   clock,
	input  logic                   rst,
	output logic [`CPU_MEM_AW-1:0] imemAddress,
	input  logic [`CPU_XLEN-1:0]   imemData,
	output logic [`CPU_MEM_AW-1:0] dmemAddress,
	output logic [`CPU_XLEN-1:0]   dmemWriteData,
	output logic                   dmemWriteEnable,
	input  logic [`CPU_XLEN-1:0]   dmemReadData
);
	// Fetch and fetch/decode
	logic [`CPU_XLEN-1:0] pc, fdPc;
	logic                 fdValid;
	// Decode
	opcodeT                 decOpcode;
	aluOpT                  decAluOp;
	branchKindT             decBranchKind;
	jumpKindT               decJumpKind;
	logic [`CPU_REG_AW-1:0] decRd, decReadA, decReadB;
	logic [4:0]             decShamt;
	logic [`CPU_XLEN-1:0]   decImmediate, decTarget, rfDataA, rfDataB;
	logic                   decRegWrite, decUseImmediate, decLoad, decStore, decIsSetx;
	// Decode/execute
	opcodeT                 dxOpcode;
	aluOpT                  dxAluOp;
	branchKindT             dxBranchKind;
	jumpKindT               dxJumpKind;
	logic [`CPU_REG_AW-1:0] dxRd, dxReadA, dxReadB;
	logic [4:0]             dxShamt;
	logic [`CPU_XLEN-1:0]   dxPc, dxImmediate, dxTarget, dxDataA, dxDataB;
	logic                   dxValid, dxRegWrite, dxUseImmediate, dxLoad, dxStore, dxIsSetx;
	// Execute
	bypassSelT              bypassA, bypassB;
	logic [`CPU_XLEN-1:0]   operandA, operandB, exResult, exRedirectPc;
	logic [`CPU_REG_AW-1:0] exDest;
	logic                   exWriteError, exRedirect, takeRedirect, stall, bypassStoreData;
	// Execute/memory and memory/writeback
	logic [`CPU_XLEN-1:0]   xmResult, xmStoreData, mwResult, wbValue;
	logic [`CPU_REG_AW-1:0] xmDest, xmStoreReg, mwDest;
	logic                   xmValid, xmRegWrite, xmLoad, xmStore;
	logic                   mwValid, mwRegWrite, mwLoad;

	// Refetch the held decode word while stalled
	assign imemAddress = stall ? fdPc[`CPU_MEM_AW-1:0] : pc[`CPU_MEM_AW-1:0];
	assign takeRedirect = dxValid && exRedirect;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= `CPU_XLEN'(`CPU_RESET_PC);
			fdValid <= 1'b0;
		end else if (takeRedirect) begin
			pc <= exRedirectPc;
			fdValid <= 1'b0; // Kill the word in flight
		end else if (!stall) begin
			pc <= pc + `CPU_XLEN'(1);
			fdValid <= 1'b1;
		end
	end

	always_ff @(posedge clock)
		if (!stall) fdPc <= pc;

	instructionDecoder decoder (
		.instruction(imemData), .opcode(decOpcode), .rd(decRd), .rs(), .rt(),
		.shamt(decShamt), .aluOp(decAluOp), .immediate(decImmediate), .target(decTarget),
		.readRegA(decReadA), .readRegB(decReadB), .regWrite(decRegWrite),
		.useImmediate(decUseImmediate), .memLoad(decLoad), .memStore(decStore),
		.isSetx(decIsSetx), .branchKind(decBranchKind), .jumpKind(decJumpKind)
	);

	registerFile regFile (
		.clock(clock), .rst(rst), .readRegA(decReadA), .readRegB(decReadB),
		.writeReg(mwDest), .writeData(wbValue), .writeEnable(mwValid && mwRegWrite),
		.readDataA(rfDataA), .readDataB(rfDataB)
	);

	hazardUnit hazards (
		.decodeReadA(decReadA), .decodeReadB(decReadB),
		.executeReadA(dxReadA), .executeReadB(dxReadB), .executeValid(dxValid),
		.executeDest(exDest), .executeLoad(dxLoad),
		.memoryDest(xmDest), .memoryRegWrite(xmRegWrite), .memoryValid(xmValid),
		.writebackDest(mwDest), .writebackRegWrite(mwRegWrite), .writebackValid(mwValid),
		.memoryStoreReg(xmStoreReg), .memoryStore(xmStore),
		.stall(stall), .bypassA(bypassA), .bypassB(bypassB), .bypassStoreData(bypassStoreData)
	);

	always_ff @(posedge clock) begin
		if (rst) dxValid <= 1'b0;
		else dxValid <= fdValid && !stall && !takeRedirect; // Bubble on stall or flush
	end

	always_ff @(posedge clock) begin
		dxPc <= fdPc;
		dxOpcode <= decOpcode;
		dxAluOp <= decAluOp;
		dxBranchKind <= decBranchKind;
		dxJumpKind <= decJumpKind;
		dxRd <= decRd;
		dxReadA <= decReadA;
		dxReadB <= decReadB;
		dxShamt <= decShamt;
		dxImmediate <= decImmediate;
		dxTarget <= decTarget;
		dxDataA <= rfDataA;
		dxDataB <= rfDataB;
		dxRegWrite <= decRegWrite;
		dxUseImmediate <= decUseImmediate;
		dxLoad <= decLoad;
		dxStore <= decStore;
		dxIsSetx <= decIsSetx;
	end

	function automatic logic [`CPU_XLEN-1:0] pickOperand(input bypassSelT sel,
		input logic [`CPU_XLEN-1:0] fromRegs);
		case (sel)
			bypFromMemory: return xmResult;
			bypFromWriteback: return wbValue;
			default: return fromRegs;
		endcase
	endfunction

	assign operandA = pickOperand(bypassA, dxDataA);
	assign operandB = pickOperand(bypassB, dxDataB);

	executeUnit execute (
		.operandA(operandA), .operandB(operandB), .immediate(dxImmediate),
		.target(dxTarget), .pc(dxPc), .aluOp(dxAluOp), .shamt(dxShamt), .opcode(dxOpcode),
		.useImmediate(dxUseImmediate), .isSetx(dxIsSetx), .branchKind(dxBranchKind),
		.jumpKind(dxJumpKind), .result(exResult), .writeError(exWriteError),
		.redirect(exRedirect), .redirectPc(exRedirectPc)
	);

	// Destination settled here so bypass compares the real target
	always_comb begin
		if (dxJumpKind == jmpJal) exDest = `CPU_REG_AW'(`CPU_REG_LINK);
		else if (exWriteError || dxIsSetx) exDest = `CPU_REG_AW'(`CPU_REG_ERROR);
		else exDest = dxRd;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			xmValid <= 1'b0;
			mwValid <= 1'b0;
		end else begin
			xmValid <= dxValid;
			mwValid <= xmValid;
		end
	end

	always_ff @(posedge clock) begin
		xmResult <= exResult;
		xmStoreData <= operandB; // sw data from rd
		xmDest <= exDest;
		xmStoreReg <= dxReadB;
		xmRegWrite <= dxRegWrite;
		xmLoad <= dxLoad;
		xmStore <= dxStore;
		mwResult <= xmResult;
		mwDest <= xmDest;
		mwRegWrite <= xmRegWrite;
		mwLoad <= xmLoad;
	end

	assign dmemAddress = xmResult[`CPU_MEM_AW-1:0];
	assign dmemWriteData = bypassStoreData ? wbValue : xmStoreData;
	assign dmemWriteEnable = xmValid && xmStore;

	// Load data returns a cycle after the address
	assign wbValue = mwLoad ? dmemReadData : mwResult;

endmodule

// File: verification/clockGenerator.sv
`timescale 1ns/1ns

module clockGenerator #(
	parameter int HalfPeriod = 2 // 4 ns period
) (
	output logic clock
);
	initial begin
		clock = 1'b0;
	end

	always #HalfPeriod clock = ~clock;

endmodule

// File: verification/storeChecker.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module storeChecker (
	input logic                   clock,
	input logic                   rst,
	input logic [`CPU_MEM_AW-1:0] imemAddress,
	input logic [`CPU_MEM_AW-1:0] dmemAddress,
	input logic [`CPU_XLEN-1:0]   dmemWriteData,
	input logic                   dmemWriteEnable
);
	int errorCount = 0; // Whole run
	int testErrors = 0; // Current test only
	int storeIndex = 0; // Next expected store
	int testsPassed = 0;
	int testsFailed = 0;
	logic leavingReset = 1'b0;

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic startTest();
		storeIndex = 0;
		testErrors = 0;
	endtask

	// Compare one store against the model's list
	task automatic compareStore();
		if (storeIndex >= cpuTestbench.expectedCount) begin
			$display("Extra store to address %h with data %h", dmemAddress, dmemWriteData);
			noteError();
		end else begin
			if (dmemAddress !== cpuTestbench.expectedAddress[storeIndex]) begin
				$display("FAILED dmemAddress expected %h got %h",
					cpuTestbench.expectedAddress[storeIndex], dmemAddress);
				noteError();
			end
			if (dmemWriteData !== cpuTestbench.expectedData[storeIndex]) begin
				$display("FAILED dmemWriteData expected %h got %h",
					cpuTestbench.expectedData[storeIndex], dmemWriteData);
				noteError();
			end
		end
		storeIndex++;
	endtask

	// Values sampled at the edge are the settled ones of the closing cycle
	always @(posedge clock) begin
		if (rst) begin
			if (dmemWriteEnable === 1'b1) begin
				$display("A store was issued while reset was held");
				noteError();
			end
			leavingReset = 1'b1;
		end else begin
			if (leavingReset && imemAddress !== '0) begin // First fetch must be word 0
				$display("First fetch after reset went to address %h instead of 0", imemAddress);
				noteError();
			end
			leavingReset = 1'b0;
			if (dmemWriteEnable === 1'b1)
				compareStore();
		end
	end

	task automatic finishTest(input int testNumber);
		if (storeIndex < cpuTestbench.expectedCount) begin
			$display("Test %0d saw only %0d of %0d expected stores", testNumber, storeIndex,
				cpuTestbench.expectedCount);
			noteError();
		end
		if (testErrors == 0) begin
			testsPassed++;
			$display("Test %0d passed with %0d stores checked", testNumber, storeIndex);
		end else begin
			testsFailed++;
			$display("Test %0d failed with %0d mismatches", testNumber, testErrors);
		end
	endtask

endmodule

// File: verification/cpuTestbench.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpuTestbench import cpuPkg::*; ();
	localparam int NumTests = 5;
	localparam int ProgLen = 60;
	localparam int HaltPc = ProgLen - 1; // j to itself lives here
	localparam int MemWords = 2**`CPU_MEM_AW;
	localparam int CycleLimit = NumTests * ProgLen * 3 + 200;

	logic                   clock, rst;
	logic [`CPU_MEM_AW-1:0] imemAddress, dmemAddress;
	logic [`CPU_XLEN-1:0]   imemData, dmemReadData, dmemWriteData;
	logic                   dmemWriteEnable;

	logic [`CPU_XLEN-1:0] imem [0:MemWords-1];
	logic [`CPU_XLEN-1:0] dmem [0:MemWords-1];
	logic [`CPU_XLEN-1:0] modelMem [0:MemWords-1]; // Reference model's data memory
	logic [`CPU_XLEN-1:0] modelRegs [0:31];
	logic [`CPU_XLEN-1:0] prog [0:ProgLen-1];
	logic [`CPU_MEM_AW-1:0] expectedAddress [0:ProgLen-1]; // Read by storeChecker
	logic [`CPU_XLEN-1:0]   expectedData [0:ProgLen-1];
	int expectedCount;
	int cycleCount;
	int slot; // Next free program word

	clockGenerator clocks (.clock(clock));

	cpuPipeline UUT (
		.clock(clock), .rst(rst), .imemAddress(imemAddress), .imemData(imemData),
		.dmemAddress(dmemAddress), .dmemWriteData(dmemWriteData),
		.dmemWriteEnable(dmemWriteEnable), .dmemReadData(dmemReadData)
	);

	storeChecker storeCheck (
		.clock(clock), .rst(rst), .imemAddress(imemAddress), .dmemAddress(dmemAddress),
		.dmemWriteData(dmemWriteData), .dmemWriteEnable(dmemWriteEnable)
	);

	// Both memories answer one cycle after the address
	always @(posedge clock) begin
		imemData <= imem[imemAddress];
		dmemReadData <= dmem[dmemAddress];
		if (dmemWriteEnable)
			dmem[dmemAddress] <= dmemWriteData;
	end

	function automatic logic [31:0] encodeR(input aluOpT op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {opR, rd, rs, rt, shamt, op, 2'b00};
	endfunction

	function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rd,
		input logic [4:0] rs, input logic [16:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input opcodeT op, input logic [26:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr + 32'd1) * 32'h9E3779B9; // Differs in every address bit
	endfunction

	// Avoids r29 kept for jr and the special r30 and r31
	function automatic logic [4:0] randomReg();
		return 5'(1 + $urandom % 28);
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[slot] = word;
		slot++;
	endtask

	task automatic emitStore(input logic [4:0] dataReg);
		emit(encodeI(opSw, dataReg, 5'd0, 17'($urandom % 64))); // Base r0 keeps 64 words
	endtask

	// Chunks whose control transfers land on chunk starts or inside the chunk
	task automatic generateProgram();
		logic [4:0] a, b, c;
		int kind;
		slot = 0;
		while (slot < HaltPc) begin
			a = randomReg();
			b = randomReg();
			c = randomReg();
			kind = (slot + 5 > HaltPc) ? 7 : int'($urandom % 8);
			case (kind)
				0: begin // Dependent ALU chain
					emit(encodeI(opAddi, a, 5'd0, 17'($urandom)));
					emit(encodeR(aluOpT'($urandom % 6), b, a, c, 5'($urandom)));
					emitStore(b);
				end
				1: begin // Load then immediate use
					emit(encodeI(opLw, a, 5'd0, 17'($urandom % 64)));
					emit(encodeR(aluAdd, b, a, c, 5'd0));
					emitStore(($urandom % 2) ? a : b);
				end
				2: begin // Two stores in the branch shadow
					emit(encodeI(opAddi, a, 5'd0, 17'($urandom % 8)));
					emit(encodeI(opAddi, b, 5'd0, 17'($urandom % 8)));
					emit(encodeI(($urandom % 2) ? opBne : opBlt, a, b, 17'd2));
					emitStore(a);
					emitStore(b);
				end
				3: begin
					emit(encodeJ(opJal, 27'(slot + 2)));
					emitStore(c); // Shadow
					emitStore(5'd31);
				end
				4: begin
					emit(encodeI(opAddi, 5'd29, 5'd0, 17'(slot + 3)));
					emit(encodeI(opJr, 5'd29, 5'd0, 17'd0));
					emitStore(a); // Skipped
					emitStore(5'd29);
				end
				5: begin // 0x80000000 makes every flavor overflow
					emit(encodeI(opAddi, a, 5'd0, 17'd1));
					emit(encodeR(aluSll, b, a, 5'd0, 5'd31));
					case ($urandom % 3)
						0: emit(encodeR(aluAdd, c, b, b, 5'd0));
						1: emit(encodeI(opAddi, c, b, 17'h1ffff));
						default: emit(encodeR(aluSub, c, b, a, 5'd0));
					endcase
					emitStore(5'd30);
				end
				6: begin
					emit(encodeJ(opSetx, ($urandom % 2) ? 27'($urandom) : 27'd0));
					emit(encodeJ(opBex, 27'(slot + 2)));
					emitStore(a);
					emitStore(5'd30);
				end
				default: begin // Single filler
					case ($urandom % 3)
						0: emit(encodeR(aluOpT'($urandom % 6), a, b, c, 5'($urandom)));
						1: emit(encodeI(opAddi, a, b, 17'($urandom)));
						default: emitStore(a);
					endcase
				end
			endcase
		end
		prog[HaltPc] = encodeJ(opJ, 27'(HaltPc));
	endtask

	task automatic writeModelReg(input logic [4:0] idx, input logic [31:0] value);
		if (idx != 5'd0)
			modelRegs[idx] = value;
	endtask

	// ISA-level execution, one instruction at a time
	task automatic runModel();
		logic [31:0] ins, a, b, s, imm, target;
		logic [4:0] rd, rs, rt, shamt;
		logic [`CPU_MEM_AW-1:0] addr;
		int pc, nextPc, steps;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < MemWords; i++)
			modelMem[i] = fillWord(i);
		expectedCount = 0;
		pc = 0;
		steps = 0;
		while (pc != HaltPc && steps < 1000) begin
			ins = prog[pc];
			rd = ins[26:22];
			rs = ins[21:17];
			rt = ins[16:12];
			shamt = ins[11:7];
			imm = {{15{ins[16]}}, ins[16:0]};
			target = {5'd0, ins[26:0]};
			a = modelRegs[rs];
			b = modelRegs[rt];
			addr = `CPU_MEM_AW'(a + imm);
			nextPc = pc + 1;
			case (opcodeT'(ins[31:27]))
				opR: case (aluOpT'(ins[6:2]))
					aluAdd: begin
						s = a + b;
						if (a[31] == b[31] && s[31] != a[31]) modelRegs[30] = `CPU_ERR_ADD;
						else writeModelReg(rd, s);
					end
					aluSub: begin
						s = a - b;
						if (a[31] != b[31] && s[31] != a[31]) modelRegs[30] = `CPU_ERR_SUB;
						else writeModelReg(rd, s);
					end
					aluAnd: writeModelReg(rd, a & b);
					aluOr: writeModelReg(rd, a | b);
					aluSll: writeModelReg(rd, a << shamt);
					aluSra: writeModelReg(rd, $signed(a) >>> shamt);
					default: ;
				endcase
				opAddi: begin
					s = a + imm;
					if (a[31] == imm[31] && s[31] != a[31]) modelRegs[30] = `CPU_ERR_ADDI;
					else writeModelReg(rd, s);
				end
				opLw: writeModelReg(rd, modelMem[addr]);
				opSw: begin
					expectedAddress[expectedCount] = addr;
					expectedData[expectedCount] = modelRegs[rd];
					expectedCount++;
					modelMem[addr] = modelRegs[rd];
				end
				opBne: if (modelRegs[rd] != a) nextPc = pc + 1 + int'($signed(imm));
				opBlt: begin
					if ($signed(modelRegs[rd]) < $signed(a))
						nextPc = pc + 1 + int'($signed(imm));
				end
				opJ: nextPc = target;
				opJal: begin
					modelRegs[31] = pc + 1;
					nextPc = target;
				end
				opJr: nextPc = modelRegs[rd];
				opSetx: modelRegs[30] = target;
				opBex: if (modelRegs[30] != '0) nextPc = target;
				default: ;
			endcase
			pc = nextPc;
			steps++;
		end
		if (pc != HaltPc) begin
			$display("Reference model never reached the halt address");
			storeCheck.noteError();
		end
	endtask

	task automatic runTest(input int testNumber);
		int haltCycles;
		@(posedge clock);
		rst <= 1'b1;
		storeCheck.startTest();
		generateProgram();
		runModel();
		for (int i = 0; i < MemWords; i++) begin
			imem[i] = (i < ProgLen) ? prog[i] : '0; // Zero word is a no-op add
			dmem[i] = fillWord(i);
		end
		repeat (16) @(posedge clock);
		rst <= 1'b0;
		haltCycles = 0;
		while (haltCycles < 8) begin // Fetch circles through the halt loop
			@(posedge clock);
			if (imemAddress >= HaltPc && imemAddress <= HaltPc + 2) haltCycles++;
			else haltCycles = 0;
		end
		storeCheck.finishTest(testNumber);
	endtask

	// Run length guard
	always @(posedge clock) begin
		if (!rst)
			cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout after %0d cycles without reaching the halt loop", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		imemData = '0;
		dmemReadData = '0;
		cycleCount = 0;
		void'($urandom(13));
		for (int t = 1; t <= NumTests; t++)
			runTest(t);
		$display("Tests passed %0d, failed %0d, errors %0d", storeCheck.testsPassed,
			storeCheck.testsFailed, storeCheck.errorCount);
		if (storeCheck.errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: cpuPipeline.f
+incdir+source
source/cpuPkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/hazardUnit.sv
source/executeUnit.sv
source/cpuPipeline.sv
verification/clockGenerator.sv
verification/storeChecker.sv
verification/cpuTestbench.sv

// File: Bender.yml
package:
  name: cpuPipeline

sources:
  - include_dirs:
      - source
    files:
      - source/cpuPkg.sv
      - source/instructionDecoder.sv
      - source/registerFile.sv
      - source/hazardUnit.sv
      - source/executeUnit.sv
      - source/cpuPipeline.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/clockGenerator.sv
      - verification/storeChecker.sv
      - verification/cpuTestbench.sv
